// ==== Bender.yml ====
package:
  name: ethRx

sources:
  - hdl/ethRxPkg.sv
  - hdl/rxStateMachine.sv
  - hdl/rxNibbleAssembler.sv
  - hdl/rxCounters.sv
  - hdl/rxCrcCheck.sv
  - hdl/ethRx.sv
  - target: test
    files:
      - tb/rxClockGen.sv
      - tb/ethRxTb.sv

// ==== ethRx.f ====
hdl/ethRxPkg.sv
hdl/rxStateMachine.sv
hdl/rxNibbleAssembler.sv
hdl/rxCounters.sv
hdl/rxCrcCheck.sv
hdl/ethRx.sv
tb/rxClockGen.sv
tb/ethRxTb.sv

// ==== hdl/ethRx.sv ====
`timescale 1ns/1ps

module ethRx import ethRxPkg::*;
(
        input  logic       MRxClk,
        input  logic       Reset,
        input  logic [3:0] MRxD,
        input  logic       MRxDV,
        input  logic       Transmitting,
        output logic [7:0] rxData,
        output logic       rxDataValid,
        output logic       rxEndFrame,
        output rxStatusT   rxStatus
);

        rxStateT                 state;
        rxCountFlagsT            countFlags;
        logic [byteCntWidth-1:0] byteCount;
        logic                    crcError;
        logic                    frameStart;

        rxStateMachine stateMachine (
                .MRxClk       (MRxClk),
                .Reset        (Reset),
                .MRxDV        (MRxDV),
                .MRxD         (MRxD),
                .Transmitting (Transmitting),
                .countFlags   (countFlags),
                .state        (state)
        );

        rxNibbleAssembler nibbleAssembler (
                .MRxClk      (MRxClk),
                .Reset       (Reset),
                .MRxD        (MRxD),
                .MRxDV       (MRxDV),
                .state       (state),
                .byteCount   (byteCount),
                .crcError    (crcError),
                .rxData      (rxData),
                .rxDataValid (rxDataValid),
                .frameStart  (frameStart),
                .rxEndFrame  (rxEndFrame),
                .rxStatus    (rxStatus)
        );

        rxCounters counters (
                .MRxClk      (MRxClk),
                .Reset       (Reset),
                .MRxD        (MRxD),
                .MRxDV       (MRxDV),
                .state       (state),
                .frameStart  (frameStart),
                .rxDataValid (rxDataValid),
                .countFlags  (countFlags),
                .byteCount   (byteCount)
        );

        rxCrcCheck crcCheck (
                .MRxClk      (MRxClk),
                .Reset       (Reset),
                .frameStart  (frameStart),
                .rxData      (rxData),
                .rxDataValid (rxDataValid),
                .crcError    (crcError)
        );

endmodule

// ==== hdl/ethRxPkg.sv ====
package ethRxPkg;

        // frame limits count destination address through FCS
        localparam int maxFrameBytes = 1518;
        localparam int ifgMinCycles = 24;
        localparam int byteCntWidth = 11;

        localparam logic [3:0] preambleNibble = 4'h5;
        localparam logic [3:0] sfdNibble = 4'hD;

        // remainder left by a frame with a good FCS
        localparam logic [31:0] crcResidue = 32'hC704DD7B;

        // one-hot receive state
        typedef struct packed {
                logic idle;
                logic preamble;
                logic sfd;
                logic data0;
                logic data1;
                logic drop;
        } rxStateT;

        typedef struct packed {
                logic ifgDone;
                logic maxFrame;
        } rxCountFlagsT;

        typedef struct packed {
                logic                    crcError;
                logic                    tooLong;
                logic [byteCntWidth-1:0] byteCount;
        } rxStatusT;

endpackage

// ==== hdl/rxCounters.sv ====
`timescale 1ns/1ps

module rxCounters import ethRxPkg::*;
(
        input  logic                    MRxClk,
        input  logic                    Reset,
        input  logic [3:0]              MRxD,
        input  logic                    MRxDV,
        input  rxStateT                 state,
        input  logic                    frameStart,
        input  logic                    rxDataValid,
        output rxCountFlagsT            countFlags,
        output logic [byteCntWidth-1:0] byteCount
);

        logic [byteCntWidth-1:0]            nextByteCount;
        logic [$clog2(ifgMinCycles+1)-1:0]  gapCount;
        logic                               gapClear;
        logic                               gapCounting;

        // include the byte arriving this cycle so data0 can stop at the limit
        assign nextByteCount = frameStart ? '0 :
                byteCount + {{(byteCntWidth-1){1'b0}}, rxDataValid};

        assign countFlags.maxFrame = (nextByteCount == byteCntWidth'(maxFrameBytes));
        assign countFlags.ifgDone = (gapCount == ifgMinCycles);

        assign gapClear = state.drop | (state.sfd & MRxDV & (MRxD == sfdNibble));
        assign gapCounting = state.idle | state.preamble | state.sfd;

        always_ff @(posedge MRxClk or posedge Reset)
        begin
                if (Reset)
                        byteCount <= '0;
                else
                        byteCount <= nextByteCount;
        end

        // saturating gap counter
        always_ff @(posedge MRxClk or posedge Reset)
        begin
                if (Reset)
                        gapCount <= '0;
                else if (gapClear)
                        gapCount <= '0;
                else if (gapCounting & ~countFlags.ifgDone)
                        gapCount <= gapCount + 1'b1;
        end

endmodule

// ==== hdl/rxCrcCheck.sv ====
`timescale 1ns/1ps

module rxCrcCheck import ethRxPkg::*;
(
        input  logic       MRxClk,
        input  logic       Reset,
        input  logic       frameStart,
        input  logic [7:0] rxData,
        input  logic       rxDataValid,
        output logic       crcError
);

        localparam logic [31:0] crcPoly = 32'h04C11DB7;
        localparam logic [31:0] crcPolyRefl = {<<{crcPoly}};
        // register is bit reversed against the residue
        localparam logic [31:0] crcResidueRefl = {<<{crcResidue}};

        logic [31:0] crcReg;

        // one byte taken LSB first
        function automatic logic [31:0] crcNextByte(input logic [31:0] crc,
                                                    input logic [7:0] data);
                logic [31:0] c;
                c = crc ^ {24'h0, data};
                for (int i = 0; i < 8; i++)
                begin
                        if (c[0])
                                c = (c >> 1) ^ crcPolyRefl;
                        else
                                c = c >> 1;
                end
                return c;
        endfunction

        always_ff @(posedge MRxClk or posedge Reset)
        begin
                if (Reset)
                        crcReg <= '1;
                else if (frameStart)
                        crcReg <= '1;
                else if (rxDataValid)
                        crcReg <= crcNextByte(crcReg, rxData);
        end

        assign crcError = (crcReg != crcResidueRefl);

endmodule

// ==== hdl/rxNibbleAssembler.sv ====
`timescale 1ns/1ps

module rxNibbleAssembler import ethRxPkg::*;
(
        input  logic                    MRxClk,
        input  logic                    Reset,
        input  logic [3:0]              MRxD,
        input  logic                    MRxDV,
        input  rxStateT                 state,
        input  logic [byteCntWidth-1:0] byteCount,
        input  logic                    crcError,
        output logic [7:0]              rxData,
        output logic                    rxDataValid,
        output logic                    frameStart,
        output logic                    rxEndFrame,
        output rxStatusT                rxStatus
);

        rxStateT    prevState;
        logic [3:0] lowNibble;
        logic       dataExit;

        // first data0 cycle right after sfd
        assign frameStart = state.data0 & prevState.sfd;

        // left the data states for idle or drop
        assign dataExit = (prevState.data0 | prevState.data1) & ~(state.data0 | state.data1);

        always_ff @(posedge MRxClk or posedge Reset)
        begin
                if (Reset)
                begin
                        prevState <= '0;
                        rxDataValid <= 1'b0;
                        rxEndFrame <= 1'b0;
                end
                else
                begin
                        prevState <= state;
                        rxDataValid <= state.data1 & MRxDV;
                        rxEndFrame <= dataExit;
                end
        end

        always_ff @(posedge MRxClk)
        begin
                if (state.data0 & MRxDV)
                        lowNibble <= MRxD;
                if (state.data1 & MRxDV)
                        rxData <= {MRxD, lowNibble};
                // exit into drop means the length limit cut the frame
                if (dataExit)
                begin
                        rxStatus.crcError <= crcError;
                        rxStatus.tooLong <= state.drop;
                        rxStatus.byteCount <= byteCount;
                end
        end

endmodule

// ==== hdl/rxStateMachine.sv ====
`timescale 1ns/1ps

module rxStateMachine import ethRxPkg::*;
(
        input  logic         MRxClk,
        input  logic         Reset,
        input  logic         MRxDV,
        input  logic [3:0]   MRxD,
        input  logic         Transmitting,
        input  rxCountFlagsT countFlags,
        output rxStateT      state
);

        logic mRxDEq5;
        logic mRxDEqD;
        logic startIdle;
        logic startPreamble;
        logic startSfd;
        logic startData0;
        logic startData1;
        logic startDrop;

        assign mRxDEq5 = (MRxD == preambleNibble);
        assign mRxDEqD = (MRxD == sfdNibble);

        // one start term per state
        assign startIdle = ~MRxDV & (state.drop | state.preamble | state.sfd |
                                     state.data0 | state.data1);
        assign startPreamble = MRxDV & ~mRxDEq5 & state.idle & ~Transmitting;
        assign startSfd = MRxDV & mRxDEq5 & ((state.idle & ~Transmitting) | state.preamble);
        assign startData0 = MRxDV & ((state.sfd & mRxDEqD & countFlags.ifgDone) |
                                     state.data1);
        assign startData1 = MRxDV & state.data0 & ~countFlags.maxFrame;
        assign startDrop = MRxDV & ((state.idle & Transmitting) |
                                    (state.sfd & mRxDEqD & ~countFlags.ifgDone) |
                                    (state.data0 & countFlags.maxFrame));

        // comes out of reset in drop so a frame already on the line is ignored
        always_ff @(posedge MRxClk or posedge Reset)
        begin
                if (Reset)
                begin
                        state <= '0;
                        state.drop <= 1'b1;
                end
                else
                begin
                        if (startPreamble | startSfd | startDrop)
                                state.idle <= 1'b0;
                        else if (startIdle)
                                state.idle <= 1'b1;

                        if (startIdle)
                                state.drop <= 1'b0;
                        else if (startDrop)
                                state.drop <= 1'b1;

                        if (startSfd | startIdle | startDrop)
                                state.preamble <= 1'b0;
                        else if (startPreamble)
                                state.preamble <= 1'b1;

                        if (startPreamble | startIdle | startData0 | startDrop)
                                state.sfd <= 1'b0;
                        else if (startSfd)
                                state.sfd <= 1'b1;

                        if (startIdle | startData1 | startDrop)
                                state.data0 <= 1'b0;
                        else if (startData0)
                                state.data0 <= 1'b1;

                        if (startIdle | startData0 | startDrop)
                                state.data1 <= 1'b0;
                        else if (startData1)
                                state.data1 <= 1'b1;
                end
        end

endmodule

// ==== tb/ethRxTb.sv ====
`timescale 1ns/1ps

module ethRxTb import ethRxPkg::*; ();

        logic       MRxClk;
        logic       Reset;
        logic [3:0] MRxD;
        logic       MRxDV;
        logic       Transmitting;
        logic [7:0] rxData;
        logic       rxDataValid;
        logic       rxEndFrame;
        rxStatusT   rxStatus;

        // one entry per frame record
        string      recName[$];
        int         recGap[$];
        int         recTx[$];
        int         recCount[$];
        int         recOffset[$];
        int         recAccept[$];
        int         recCrc[$];
        int         recTooLong[$];
        logic [7:0] fileBytes[$];

        logic [7:0] seenBytes[$];
        rxStatusT   lastStatus;
        int         endCount = 0;
        string      currentTest = "setup";
        logic [31:0] lfsrState = 32'h54b2;
        longint     watchLimitNs = 0;
        int         quietCycles = 6;

        rxClockGen clockGen (
                .MRxClk (MRxClk),
                .Reset  (Reset)
        );

        ethRx dut_i (
                .MRxClk       (MRxClk),
                .Reset        (Reset),
                .MRxD         (MRxD),
                .MRxDV        (MRxDV),
                .Transmitting (Transmitting),
                .rxData       (rxData),
                .rxDataValid  (rxDataValid),
                .rxEndFrame   (rxEndFrame),
                .rxStatus     (rxStatus)
        );

        task automatic stopOnFailure();
                $display("** FAIL **");
                $fatal(1, "run stopped at the first failure");
        endtask

        task automatic checkValue(input string what, input logic [31:0] expected,
                                  input logic [31:0] actual);
                if (actual !== expected)
                begin
                        $display("error: %s, %s expected 0x%0h actual 0x%0h",
                                 currentTest, what, expected, actual);
                        stopOnFailure();
                end
        endtask

        // galois form with taps 32 30 26 25
        function automatic logic [31:0] lfsrStep(input logic [31:0] s);
                return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
        endfunction

        function automatic logic [7:0] nextRandomByte();
                logic [7:0] b;
                for (int i = 0; i < 8; i++)
                begin
                        b[i] = lfsrState[0];
                        lfsrState = lfsrStep(lfsrState);
                end
                return b;
        endfunction

        task automatic driveNibble(input logic [3:0] nibble, input logic valid);
                @(posedge MRxClk);
                #1;
                MRxD = nibble;
                MRxDV = valid;
        endtask

        task automatic sendByte(input logic [7:0] b);
                driveNibble(b[3:0], 1'b1);
                driveNibble(b[7:4], 1'b1);
        endtask

        task automatic sendFrame(input int offset, input int count);
                repeat (7)
                        sendByte(8'h55);
                sendByte(8'hD5);
                for (int i = 0; i < count; i++)
                        sendByte(fileBytes[offset + i]);
        endtask

        task automatic loadVectors();
                int         fd;
                int         n;
                int         c;
                int         gap;
                int         tx;
                int         count;
                int         crcFlag;
                int         longFlag;
                logic [7:0] byteVal;
                string      tok;
                string      name;
                string      outcome;
                longint     cycles;
                cycles = 0;
                fd = $fopen("tb/ethRxVectors.txt", "r");
                if (fd == 0)
                begin
                        $display("could not open tb/ethRxVectors.txt");
                        stopOnFailure();
                end
                else
                begin
                        while ($fscanf(fd, "%s", tok) == 1)
                        begin
                                if (tok == "#")
                                begin
                                        c = $fgetc(fd);
                                        while (c != "\n" && c != -1)
                                                c = $fgetc(fd);
                                end
                                else
                                begin
                                        n = $fscanf(fd, "%s %d %d %d", name, gap, tx, count);
                                        recOffset.push_back(fileBytes.size());
                                        for (int i = 0; i < count; i++)
                                        begin
                                                if (tok == "long")
                                                        byteVal = nextRandomByte();
                                                else
                                                        n += $fscanf(fd, "%h", byteVal);
                                                fileBytes.push_back(byteVal);
                                        end
                                        n += $fscanf(fd, "%s %d %d", outcome, crcFlag, longFlag);
                                        if (n != ((tok == "long") ? 7 : 7 + count))
                                        begin
                                                $display("vectors record %s is malformed", name);
                                                stopOnFailure();
                                        end
                                        recName.push_back(name);
                                        recGap.push_back(gap);
                                        recTx.push_back(tx);
                                        recCount.push_back(count);
                                        recAccept.push_back(outcome == "accept");
                                        recCrc.push_back(crcFlag);
                                        recTooLong.push_back(longFlag);
                                        // preamble and sfd are 16 nibbles
                                        cycles += gap + 16 + 2 * count + quietCycles;
                                end
                        end
                        $fclose(fd);
                        watchLimitNs = 2 * cycles * 4;
                end
        endtask

        always @(negedge MRxClk)
        begin
                if (rxDataValid === 1'b1)
                        seenBytes.push_back(rxData);
                if (rxEndFrame === 1'b1)
                begin
                        endCount++;
                        lastStatus = rxStatus;
                end
        end

        initial
        begin
                wait (watchLimitNs > 0);
                #(watchLimitNs);
                $display("timed out after %0d ns before all frames were sent", watchLimitNs);
                stopOnFailure();
        end

        initial
        begin
                int expLen;
                int endBefore;
                int waited;
                MRxD = 4'h0;
                MRxDV = 1'b0;
                Transmitting = 1'b0;
                loadVectors();
                for (int r = 0; r < recName.size(); r++)
                begin
                        currentTest = recName[r];
                        seenBytes.delete();
                        endBefore = endCount;
                        Transmitting = (recTx[r] != 0);
                        repeat (recGap[r])
                                driveNibble(4'h0, 1'b0);
                        sendFrame(recOffset[r], recCount[r]);
                        // keep the line idle past the end pulse or for the whole window on a drop
                        waited = 0;
                        while (waited < quietCycles &&
                               (recAccept[r] == 0 || endCount == endBefore || waited < 3))
                        begin
                                driveNibble(4'h0, 1'b0);
                                waited++;
                        end
                        if (recAccept[r] != 0)
                        begin
                                // longer frames are cut at the length limit
                                expLen = (recCount[r] > maxFrameBytes) ? maxFrameBytes : recCount[r];
                                checkValue("end pulses", 1, endCount - endBefore);
                                checkValue("bytes received", expLen, seenBytes.size());
                                for (int i = 0; i < expLen; i++)
                                        checkValue($sformatf("byte %0d", i),
                                                   fileBytes[recOffset[r] + i], seenBytes[i]);
                                checkValue("byteCount", expLen, lastStatus.byteCount);
                                checkValue("crcError", recCrc[r], lastStatus.crcError);
                                checkValue("tooLong", recTooLong[r], lastStatus.tooLong);
                        end
                        else
                        begin
                                checkValue("end pulses", 0, endCount - endBefore);
                                checkValue("bytes received", 0, seenBytes.size());
                        end
                end
                $display("** PASS **");
                $finish;
        end

endmodule

// ==== tb/ethRxVectors.txt ====
# record: frame|long name gapCycles transmitting byteCount [payload hex] accept|drop crcError tooLong
# payload holds the FCS where the CRC should pass; long records take bytes from the LFSR

# already on the line when reset is released
frame resetHeld 0 0 8 01 02 03 04 05 06 07 08 drop 0 0

# "123456789" with its FCS
frame digits 12 0 13 31 32 33 34 35 36 37 38 39 26 39 F4 CB accept 0 0

frame fox 12 0 47
    54 68 65 20 71 75 69 63 6B 20 62 72 6F 77 6E 20
    66 6F 78 20 6A 75 6D 70 73 20 6F 76 65 72 20 74
    68 65 20 6C 61 7A 79 20 64 6F 67 39 A3 4F 41
    accept 0 0

# last FCS byte flipped
frame badFcs 12 0 13 31 32 33 34 35 36 37 38 39 26 39 F4 CA accept 1 0

# gap too short after the frame before
frame shortGap 2 0 7 61 62 63 C2 41 24 35 drop 0 0
frame afterGap 12 0 7 61 62 63 C2 41 24 35 accept 0 0

# arrives while transmitting
frame whileTx 12 1 5 61 43 BE B7 E8 drop 0 0
frame afterTx 12 0 5 61 43 BE B7 E8 accept 0 0

# over the length limit
long tooLong 12 0 1530 accept 1 1

frame afterLong 12 0 13 31 32 33 34 35 36 37 38 39 26 39 F4 CB accept 0 0

// ==== tb/rxClockGen.sv ====
`timescale 1ns/1ps

module rxClockGen
(
        output logic MRxClk,
        output logic Reset
);

        initial
        begin
                MRxClk = 1'b0;
                forever #2 MRxClk = ~MRxClk;
        end

        // held for four rising edges
        initial
        begin
                Reset = 1'b1;
                repeat (4) @(posedge MRxClk);
                #1;
                Reset = 1'b0;
        end

endmodule
